// File: rtl/aluPkg.sv
`default_nettype none

package aluPkg;

    localparam int DataWidth = 32;

    typedef enum logic [7:0] {
        Nop   = 8'h00,
        Add   = 8'h01,
        Addu  = 8'h02,
        Sub   = 8'h03,
        Subu  = 8'h04,
        And   = 8'h05,
        Or    = 8'h06,
        Xor   = 8'h07,
        Nor   = 8'h08,
        Slt   = 8'h09,
        Sltu  = 8'h0a,
        Sll   = 8'h10, // shifts by the instruction's sa field
        Srl   = 8'h11,
        Sra   = 8'h12,
        Sllv  = 8'h13, // shifts by srcA[4:0]
        Srlv  = 8'h14,
        Srav  = 8'h15,
        Lui   = 8'h16,
        Clo   = 8'h18,
        Clz   = 8'h19,
        Mthi  = 8'h20,
        Mtlo  = 8'h21,
        Mult  = 8'h30,
        Multu = 8'h31,
        Div   = 8'h32,
        Divu  = 8'h33
    } aluOp_e;

    // one execute-stage instruction as the decoder hands it over
    typedef struct packed {
        aluOp_e               op;
        logic [DataWidth-1:0] srcA;
        logic [DataWidth-1:0] srcB;
        logic [4:0]           sa;
    } exReq_t;

endpackage

`default_nettype wire

// File: rtl/hiloPkg.sv
`default_nettype none

package hiloPkg;

    // both uses the all-zero code
    typedef enum logic [1:0] {
        Both = 2'b00,
        None = 2'b01,
        Lo   = 2'b10,
        Hi   = 2'b11
    } hiloSel_e;

    typedef struct packed {
        logic     write;
        hiloSel_e sel;
    } hiloWr_t;

    typedef struct packed {
        logic [aluPkg::DataWidth-1:0] hi; // remainder for a division
        logic [aluPkg::DataWidth-1:0] lo; // quotient for a division
    } hiloHalves_t;

    // a product is one wide word, a division gives two separate halves
    typedef union packed {
        logic [2*aluPkg::DataWidth-1:0] full;
        hiloHalves_t                    halves;
    } result_u;

endpackage

`default_nettype wire

// File: rtl/seqMultiplier.sv
`default_nettype none

module seqMultiplier #(
    parameter int BitsPerCycle = 1
) (
    input  logic                         clk,
    input  logic                         rstN_i,
    input  logic                         flush_i,
    input  logic                         start_i,
    input  logic                         signed_i,
    input  logic [aluPkg::DataWidth-1:0] opA_i,
    input  logic [aluPkg::DataWidth-1:0] opB_i,
    output logic                         done_o,
    output hiloPkg::result_u             product_o
);
    localparam int W = aluPkg::DataWidth;
    localparam int Steps = W / BitsPerCycle;
    localparam int StepW = $clog2(Steps) + 1;

    logic [W-1:0]     absA;
    logic [W-1:0]     absB;
    logic [2*W-1:0]   candQ;
    logic [2*W-1:0]   curCand;
    logic [W-1:0]     plierQ;
    logic [W-1:0]     curPlier;
    logic [2*W-1:0]   accQ;
    logic [2*W-1:0]   curAcc;
    logic [2*W-1:0]   partial;
    logic [2*W-1:0]   nextAcc;
    logic             negQ;
    logic             curNeg;
    logic [StepW-1:0] stepQ;
    logic             busyQ;
    logic             lastStep;
    logic             doneQ;
    hiloPkg::result_u productQ;

    assign absA = (signed_i && opA_i[W-1]) ? -opA_i : opA_i;
    assign absB = (signed_i && opB_i[W-1]) ? -opB_i : opB_i;

    // the first chunk is taken straight from the inputs on the start edge
    assign curCand  = start_i ? {{W{1'b0}}, absA} : candQ;
    assign curPlier = start_i ? absB : plierQ;
    assign curAcc   = start_i ? '0 : accQ;
    assign curNeg   = start_i ? (signed_i & (opA_i[W-1] ^ opB_i[W-1])) : negQ;
    assign lastStep = start_i ? (Steps == 1) : (stepQ == StepW'(Steps - 1));

    always_comb begin
        partial = '0;
        for (int b = 0; b < BitsPerCycle; b++) begin
            if (curPlier[b]) begin
                partial = partial + (curCand << b);
            end
        end
    end

    assign nextAcc = curAcc + partial;

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            busyQ <= 1'b0;
            stepQ <= '0;
            doneQ <= 1'b0;
        end else if (flush_i) begin
            busyQ <= 1'b0;
            stepQ <= '0;
            doneQ <= 1'b0;
        end else begin
            doneQ <= (start_i || busyQ) && lastStep;
            if (start_i || busyQ) begin
                busyQ <= !lastStep;
                stepQ <= lastStep ? '0 : (start_i ? StepW'(1) : stepQ + 1'b1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i || busyQ) begin
            accQ   <= nextAcc;
            candQ  <= curCand << BitsPerCycle;
            plierQ <= curPlier >> BitsPerCycle;
            negQ   <= curNeg;
            if (lastStep) begin
                productQ.full <= curNeg ? -nextAcc : nextAcc; // sign fix on the final chunk
            end
        end
    end

    assign done_o    = doneQ;
    assign product_o = productQ;

endmodule

`default_nettype wire

// File: rtl/seqDivider.sv
`default_nettype none

module seqDivider (
    input  logic                         clk,
    input  logic                         rstN_i,
    input  logic                         flush_i,
    input  logic                         start_i,
    input  logic                         signed_i,
    input  logic [aluPkg::DataWidth-1:0] dividend_i,
    input  logic [aluPkg::DataWidth-1:0] divisor_i,
    output logic                         done_o,
    output hiloPkg::result_u             quotRem_o
);
    localparam int W = aluPkg::DataWidth;
    localparam int StepW = $clog2(W);

    logic [W-1:0]     absDividend;
    logic [W-1:0]     absDivisor;
    logic [W-1:0]     remQ;
    logic [W-1:0]     quotQ;
    logic [W-1:0]     divisorQ;
    logic [W-1:0]     dividendQ;
    logic             negQuotQ;
    logic             negRemQ;
    logic             divZeroQ;
    logic [W:0]       shifted;
    logic [W:0]       diff;
    logic [W-1:0]     remNext;
    logic [W-1:0]     quotNext;
    logic [W-1:0]     quotFinal;
    logic [W-1:0]     remFinal;
    logic [StepW-1:0] stepQ;
    logic             busyQ;
    logic             lastStep;
    logic             doneQ;
    hiloPkg::result_u quotRemQ;

    assign absDividend = (signed_i && dividend_i[W-1]) ? -dividend_i : dividend_i;
    assign absDivisor  = (signed_i && divisor_i[W-1]) ? -divisor_i : divisor_i;

    // each restoring step moves the next dividend bit into the partial remainder
    assign shifted  = {remQ, quotQ[W-1]};
    assign diff     = shifted - {1'b0, divisorQ};
    assign remNext  = diff[W] ? shifted[W-1:0] : diff[W-1:0];
    assign quotNext = {quotQ[W-2:0], ~diff[W]};
    assign lastStep = busyQ && (stepQ == StepW'(W - 1));

    // quotient truncates toward zero and the remainder follows the dividend's sign
    assign quotFinal = divZeroQ ? '1 : (negQuotQ ? -quotNext : quotNext);
    assign remFinal  = divZeroQ ? dividendQ : (negRemQ ? -remNext : remNext);

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            busyQ <= 1'b0;
            stepQ <= '0;
            doneQ <= 1'b0;
        end else if (flush_i) begin
            busyQ <= 1'b0;
            stepQ <= '0;
            doneQ <= 1'b0;
        end else begin
            doneQ <= lastStep && !start_i;
            if (start_i) begin
                busyQ <= 1'b1; // setup edge before the 32 steps
                stepQ <= '0;
            end else if (busyQ) begin
                stepQ <= stepQ + 1'b1;
                if (lastStep) begin
                    busyQ <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            remQ      <= '0;
            quotQ     <= absDividend;
            divisorQ  <= absDivisor;
            dividendQ <= dividend_i;
            negQuotQ  <= signed_i & (dividend_i[W-1] ^ divisor_i[W-1]);
            negRemQ   <= signed_i & dividend_i[W-1];
            divZeroQ  <= (divisor_i == '0);
        end else if (busyQ) begin
            remQ  <= remNext;
            quotQ <= quotNext;
            if (lastStep) begin
                quotRemQ.halves.hi <= remFinal;
                quotRemQ.halves.lo <= quotFinal;
            end
        end
    end

    assign done_o    = doneQ;
    assign quotRem_o = quotRemQ;

endmodule

`default_nettype wire

// File: rtl/aluCore.sv
`default_nettype none

module aluCore (
    input  logic              clk,
    input  logic              rstN_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  aluPkg::exReq_t    req_i,
    input  logic              mulDone_i,
    input  hiloPkg::result_u  mulResult_i,
    input  logic              divDone_i,
    input  hiloPkg::result_u  divResult_i,
    output logic              mulStart_o,
    output logic              divStart_o,
    output logic              signed_o,
    output hiloPkg::result_u  result_o,
    output logic              overflow_o,
    output hiloPkg::hiloWr_t  hiloWr_o,
    output logic              aluStall_o
);
    localparam int W = aluPkg::DataWidth;

    function automatic logic [W-1:0] countLeading(input logic [W-1:0] v, input logic bitVal);
        logic [W-1:0] cnt;
        cnt = W'(W);
        for (int i = 0; i < W; i++) begin
            if (v[i] != bitVal) begin
                cnt = W'(W - 1 - i); // the highest mismatch wins
            end
        end
        return cnt;
    endfunction

    logic             isMul;
    logic             isDiv;
    logic             isMulti;
    logic             busyQ;
    logic             heldQ;
    logic             doneHit;
    logic             startIssue;
    logic [W-1:0]     sum;
    logic [W-1:0]     diffAB;
    logic [W-1:0]     single;
    hiloPkg::result_u unitResult;
    hiloPkg::result_u heldResultQ;

    assign isMul   = (req_i.op == aluPkg::Mult) || (req_i.op == aluPkg::Multu);
    assign isDiv   = (req_i.op == aluPkg::Div) || (req_i.op == aluPkg::Divu);
    assign isMulti = isMul || isDiv;

    assign unitResult = isMul ? mulResult_i : divResult_i;
    assign doneHit    = busyQ && (isMul ? mulDone_i : divDone_i);
    assign startIssue = isMulti && !busyQ && !heldQ; // once per instruction

    assign mulStart_o = startIssue && isMul;
    assign divStart_o = startIssue && isDiv;
    assign signed_o   = (req_i.op == aluPkg::Mult) || (req_i.op == aluPkg::Div);
    assign aluStall_o = isMulti && !heldQ && !doneHit;

    assign sum    = req_i.srcA + req_i.srcB;
    assign diffAB = req_i.srcA - req_i.srcB;

    always_comb begin
        single     = '0;
        overflow_o = 1'b0;
        case (req_i.op)
            aluPkg::Add: begin
                single     = sum;
                overflow_o = (req_i.srcA[W-1] == req_i.srcB[W-1]) && (sum[W-1] != req_i.srcA[W-1]);
            end
            aluPkg::Sub: begin
                single     = diffAB;
                overflow_o = (req_i.srcA[W-1] != req_i.srcB[W-1])
                             && (diffAB[W-1] != req_i.srcA[W-1]);
            end
            aluPkg::Addu: single = sum;
            aluPkg::Subu: single = diffAB;
            aluPkg::And:  single = req_i.srcA & req_i.srcB;
            aluPkg::Or:   single = req_i.srcA | req_i.srcB;
            aluPkg::Xor:  single = req_i.srcA ^ req_i.srcB;
            aluPkg::Nor:  single = ~(req_i.srcA | req_i.srcB);
            aluPkg::Slt:  single = W'($signed(req_i.srcA) < $signed(req_i.srcB));
            aluPkg::Sltu: single = W'(req_i.srcA < req_i.srcB);
            aluPkg::Sll:  single = req_i.srcB << req_i.sa;
            aluPkg::Srl:  single = req_i.srcB >> req_i.sa;
            aluPkg::Sra:  single = $signed(req_i.srcB) >>> req_i.sa;
            aluPkg::Sllv: single = req_i.srcB << req_i.srcA[4:0];
            aluPkg::Srlv: single = req_i.srcB >> req_i.srcA[4:0];
            aluPkg::Srav: single = $signed(req_i.srcB) >>> req_i.srcA[4:0];
            aluPkg::Lui:  single = {req_i.srcB[15:0], 16'h0000};
            aluPkg::Clo:  single = countLeading(req_i.srcA, 1'b1);
            aluPkg::Clz:  single = countLeading(req_i.srcA, 1'b0);
            aluPkg::Mtlo: single = req_i.srcA;
            default:      single = '0;
        endcase
    end

    always_comb begin
        result_o.halves.hi = '0;
        result_o.halves.lo = single;
        hiloWr_o.write     = 1'b0;
        hiloWr_o.sel       = hiloPkg::None;
        if (isMulti) begin
            result_o       = heldQ ? heldResultQ : unitResult;
            hiloWr_o.sel   = hiloPkg::Both;
            hiloWr_o.write = !stall_i && (heldQ || doneHit);
        end else if (req_i.op == aluPkg::Mthi) begin
            result_o.halves.hi = req_i.srcA;
            hiloWr_o.sel       = hiloPkg::Hi;
            hiloWr_o.write     = !stall_i;
        end else if (req_i.op == aluPkg::Mtlo) begin
            hiloWr_o.sel   = hiloPkg::Lo;
            hiloWr_o.write = !stall_i;
        end
    end

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            busyQ <= 1'b0;
            heldQ <= 1'b0;
        end else if (flush_i) begin
            busyQ <= 1'b0;
            heldQ <= 1'b0;
        end else begin
            if (startIssue) begin
                busyQ <= 1'b1;
            end else if (doneHit) begin
                busyQ <= 1'b0;
            end
            if (doneHit && stall_i) begin
                heldQ <= 1'b1; // keep the result while a later stage holds the pipeline
            end else if (heldQ && !stall_i) begin
                heldQ <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doneHit && stall_i) begin
            heldResultQ <= unitResult;
        end
    end

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
`default_nettype none

module executeStage #(
    parameter int MulBitsPerCycle = 1
) (
    input  logic             clk,
    input  logic             rstN_i,
    input  aluPkg::exReq_t   exReq_i,
    input  logic             stall_i,
    input  logic             flush_i,
    output hiloPkg::result_u result_o,
    output logic             overflow_o,
    output hiloPkg::hiloWr_t hiloWr_o,
    output logic             aluStall_o
);
    logic             mulStart;
    logic             divStart;
    logic             signedOp;
    logic             mulDone;
    logic             divDone;
    hiloPkg::result_u mulResult;
    hiloPkg::result_u divResult;

    aluCore core (
        .clk         (clk),
        .rstN_i      (rstN_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .req_i       (exReq_i),
        .mulDone_i   (mulDone),
        .mulResult_i (mulResult),
        .divDone_i   (divDone),
        .divResult_i (divResult),
        .mulStart_o  (mulStart),
        .divStart_o  (divStart),
        .signed_o    (signedOp),
        .result_o    (result_o),
        .overflow_o  (overflow_o),
        .hiloWr_o    (hiloWr_o),
        .aluStall_o  (aluStall_o)
    );

    seqMultiplier #(
        .BitsPerCycle (MulBitsPerCycle)
    ) mul (
        .clk       (clk),
        .rstN_i    (rstN_i),
        .flush_i   (flush_i),
        .start_i   (mulStart),
        .signed_i  (signedOp),
        .opA_i     (exReq_i.srcA),
        .opB_i     (exReq_i.srcB),
        .done_o    (mulDone),
        .product_o (mulResult)
    );

    seqDivider div (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .flush_i    (flush_i),
        .start_i    (divStart),
        .signed_i   (signedOp),
        .dividend_i (exReq_i.srcA),
        .divisor_i  (exReq_i.srcB),
        .done_o     (divDone),
        .quotRem_o  (divResult)
    );

endmodule

`default_nettype wire

// File: testbench/executeStage_checker.sv
`default_nettype none

module executeStage_checker (
    input logic             clk,
    input logic             rstN_i,
    input logic             stall_i,
    input logic             flush_i,
    input aluPkg::aluOp_e   op_i,
    input logic             overflow_i,
    input hiloPkg::hiloWr_t hiloWr_i,
    input logic             aluStall_i
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int StallLimit = 40;

    logic [5:0] stallRun; // consecutive cycles with the pipeline held by the ALU

    always_ff @(posedge clk or negedge rstN_i) begin
        if (!rstN_i) begin
            stallRun <= '0;
        end else if (aluStall_i) begin
            stallRun <= stallRun + 1'b1;
        end else begin
            stallRun <= '0;
        end
    end

    quietAfterReset: assert property (@(posedge clk)
        (!rstN_i || $rose(rstN_i)) |-> (!aluStall_i && !hiloWr_i.write))
        else $error("stall or HI/LO write active around reset");

    noWriteWhileStalled: assert property (@(posedge clk) disable iff (!rstN_i)
        stall_i |-> !hiloWr_i.write)
        else $error("HI/LO write issued while a later stage stalls");

    overflowOnlyAddSub: assert property (@(posedge clk) disable iff (!rstN_i)
        overflow_i |-> (op_i == aluPkg::Add || op_i == aluPkg::Sub))
        else $error("overflow flagged for an operation other than add or sub");

    stallEnds: assert property (@(posedge clk) disable iff (!rstN_i)
        stallRun < 6'(StallLimit))
        else $error("ALU stall held longer than the multi-cycle limit");

    noWriteAfterFlush: assert property (@(posedge clk) disable iff (!rstN_i)
        flush_i |=> !hiloWr_i.write)
        else $error("HI/LO write right after a flush");

endmodule

`default_nettype wire

// File: testbench/executeStage_tb.sv
`default_nettype none

module executeStage_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MulBitsPerCycle = 1;
    localparam int ClkPeriod = 40;
    localparam int DriveDelay = 2;
    localparam int ResetCycles = 8;
    localparam int OpCycleLimit = 40; // cycles one operation may take at most
    localparam int MulLatency = 32 / MulBitsPerCycle;
    localparam int DivLatency = 33;
    localparam int NumCorners = 6;
    localparam int RunsPerOp = NumCorners + 4;
    localparam int NumSingleOps = 19;
    localparam int NumOps = NumSingleOps * RunsPerOp + 4 * NumCorners + 8 + 4 * RunsPerOp + 8;
    localparam int WatchdogNs = (ResetCycles + NumOps * OpCycleLimit) * ClkPeriod + 4000;

    logic             clk;
    logic             rstN;
    aluPkg::exReq_t   exReq;
    logic             stall;
    logic             flush;
    hiloPkg::result_u result;
    logic             overflow;
    hiloPkg::hiloWr_t hiloWr;
    logic             aluStall;
    integer           seed;
    int               errors;
    int               checks;

    logic [31:0] corners [NumCorners] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                                          32'h7fff_ffff, 32'h0000_0001, 32'hffff_fff9};
    // signed add and sub overflow cases where the last pair stays in range
    logic [31:0] ovfA [NumCorners] = '{32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000,
                                       32'h0000_0000, 32'h7fff_ffff, 32'h0000_0005};
    logic [31:0] ovfB [NumCorners] = '{32'h0000_0001, 32'hffff_ffff, 32'h0000_0001,
                                       32'h8000_0000, 32'hffff_ffff, 32'h0000_0003};
    aluPkg::aluOp_e singleOps [NumSingleOps] = '{
        aluPkg::Add, aluPkg::Addu, aluPkg::Sub, aluPkg::Subu, aluPkg::And, aluPkg::Or,
        aluPkg::Xor, aluPkg::Nor, aluPkg::Slt, aluPkg::Sltu, aluPkg::Sll, aluPkg::Srl,
        aluPkg::Sra, aluPkg::Sllv, aluPkg::Srlv, aluPkg::Srav, aluPkg::Lui, aluPkg::Clo,
        aluPkg::Clz
    };

    executeStage #(
        .MulBitsPerCycle (MulBitsPerCycle)
    ) executeStage_inst (
        .clk        (clk),
        .rstN_i     (rstN),
        .exReq_i    (exReq),
        .stall_i    (stall),
        .flush_i    (flush),
        .result_o   (result),
        .overflow_o (overflow),
        .hiloWr_o   (hiloWr),
        .aluStall_o (aluStall)
    );

    bind executeStage executeStage_checker protocolCheck (
        .clk        (clk),
        .rstN_i     (rstN_i),
        .stall_i    (stall_i),
        .flush_i    (flush_i),
        .op_i       (exReq_i.op),
        .overflow_i (overflow_o),
        .hiloWr_i   (hiloWr_o),
        .aluStall_i (aluStall_o)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic logic [31:0] leadingRun(input logic [31:0] v, input logic bitVal);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == bitVal) begin
            n++;
        end
        return 32'(n);
    endfunction

    function automatic logic [31:0] refSingle(input aluPkg::aluOp_e op, input logic [31:0] a,
                                              input logic [31:0] b, input logic [4:0] sa);
        case (op)
            aluPkg::Add, aluPkg::Addu: return a + b;
            aluPkg::Sub, aluPkg::Subu: return a - b;
            aluPkg::And:  return a & b;
            aluPkg::Or:   return a | b;
            aluPkg::Xor:  return a ^ b;
            aluPkg::Nor:  return ~(a | b);
            aluPkg::Slt:  return {31'h0, $signed(a) < $signed(b)};
            aluPkg::Sltu: return {31'h0, a < b};
            aluPkg::Sll:  return b << sa;
            aluPkg::Srl:  return b >> sa;
            aluPkg::Sra:  return 32'($signed(b) >>> sa);
            aluPkg::Sllv: return b << a[4:0];
            aluPkg::Srlv: return b >> a[4:0];
            aluPkg::Srav: return 32'($signed(b) >>> a[4:0]);
            aluPkg::Lui:  return {b[15:0], 16'h0000};
            aluPkg::Clo:  return leadingRun(a, 1'b1);
            aluPkg::Clz:  return leadingRun(a, 1'b0);
            default:      return 32'h0;
        endcase
    endfunction

    function automatic logic refOverflow(input aluPkg::aluOp_e op, input logic [31:0] a,
                                         input logic [31:0] b);
        logic [32:0] wide; // one guard bit catches the signed carry out
        if (op == aluPkg::Add) begin
            wide = {a[31], a} + {b[31], b};
        end else if (op == aluPkg::Sub) begin
            wide = {a[31], a} - {b[31], b};
        end else begin
            return 1'b0;
        end
        return wide[32] != wide[31];
    endfunction

    function automatic logic [63:0] refMul(input logic sgn, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [63:0] wideA;
        logic [63:0] wideB;
        wideA = sgn ? {{32{a[31]}}, a} : {32'h0, a};
        wideB = sgn ? {{32{b[31]}}, b} : {32'h0, b};
        return wideA * wideB;
    endfunction

    function automatic logic [63:0] refDiv(input logic sgn, input logic [31:0] a,
                                           input logic [31:0] b);
        logic [32:0] magA;
        logic [32:0] magB;
        logic [31:0] quot;
        logic [31:0] rem;
        if (b == 32'h0) begin
            return {a, 32'hffff_ffff};
        end
        magA = (sgn && a[31]) ? 33'h0 - {1'b1, a} : {1'b0, a};
        magB = (sgn && b[31]) ? 33'h0 - {1'b1, b} : {1'b0, b};
        quot = 32'(magA / magB);
        rem  = 32'(magA % magB);
        if (sgn && (a[31] ^ b[31])) begin
            quot = -quot;
        end
        if (sgn && a[31]) begin
            rem = -rem;
        end
        return {rem, quot};
    endfunction

    task automatic checkValue(input string sigName, input logic [63:0] got,
                              input logic [63:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, sigName, got, exp);
            errors++;
        end
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #DriveDelay;
    endtask

    task automatic applyReq(input aluPkg::aluOp_e op, input logic [31:0] a,
                            input logic [31:0] b, input logic [4:0] sa);
        exReq.op   = op;
        exReq.srcA = a;
        exReq.srcB = b;
        exReq.sa   = sa;
    endtask

    task automatic endTest(input string name, input int mark);
        $display("test %s: %s", name, (errors == mark) ? "passed" : "failed");
    endtask

    task automatic runSingle(input aluPkg::aluOp_e op, input logic [31:0] a,
                             input logic [31:0] b, input logic [4:0] sa);
        nextCycle();
        stall = 1'b0;
        applyReq(op, a, b, sa);
        @(negedge clk);
        checkValue("result_o", result.full, {32'h0, refSingle(op, a, b, sa)});
        checkValue("overflow_o", overflow, refOverflow(op, a, b));
        checkValue("aluStall_o", aluStall, 1'b0);
        checkValue("hiloWr_o.write", hiloWr.write, 1'b0);
    endtask

    task automatic runMove(input aluPkg::aluOp_e op, input logic [31:0] a, input logic held);
        logic [63:0] expected;
        expected = (op == aluPkg::Mthi) ? {a, 32'h0} : {32'h0, a};
        nextCycle();
        stall = held;
        applyReq(op, a, $random(seed), 5'd0);
        @(negedge clk);
        checkValue("result_o", result.full, expected);
        checkValue("hiloWr_o.sel", hiloWr.sel,
                   (op == aluPkg::Mthi) ? hiloPkg::Hi : hiloPkg::Lo);
        checkValue("hiloWr_o.write", hiloWr.write, !held);
        checkValue("aluStall_o", aluStall, 1'b0);
        if (held) begin
            nextCycle();
            stall = 1'b0; // the write goes out once the later stage lets go
            @(negedge clk);
            checkValue("hiloWr_o.write", hiloWr.write, 1'b1);
        end
    endtask

    task automatic runMulti(input aluPkg::aluOp_e op, input logic [31:0] a,
                            input logic [31:0] b, input int hold);
        logic        isMul;
        logic [63:0] expected;
        int          cycles;
        isMul    = (op == aluPkg::Mult) || (op == aluPkg::Multu);
        expected = isMul ? refMul(op == aluPkg::Mult, a, b) : refDiv(op == aluPkg::Div, a, b);
        nextCycle();
        stall = (hold > 0);
        applyReq(op, a, b, 5'd0);
        @(negedge clk);
        checkValue("aluStall_o", aluStall, 1'b1);
        cycles = 0;
        while (aluStall && cycles < OpCycleLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (aluStall) begin
            $display("operation %0h did not finish within %0d cycles", op, OpCycleLimit);
            errors++;
        end else begin
            checkValue("latency", cycles, isMul ? MulLatency : DivLatency);
            checkValue("result_o", result.full, expected);
            checkValue("hiloWr_o.sel", hiloWr.sel, hiloPkg::Both);
            checkValue("hiloWr_o.write", hiloWr.write, !stall);
            for (int h = 0; h < hold; h++) begin
                nextCycle();
                if (h == hold - 1) begin
                    stall = 1'b0;
                end
                @(negedge clk);
                checkValue("aluStall_o", aluStall, 1'b0);
                checkValue("result_o", result.full, expected);
                checkValue("hiloWr_o.write", hiloWr.write, !stall);
            end
        end
    endtask

    task automatic sweepMulti(input aluPkg::aluOp_e op);
        logic [31:0] a;
        logic [31:0] b;
        for (int i = 0; i < RunsPerOp; i++) begin
            a = (i < NumCorners) ? corners[i] : $random(seed);
            b = (i < NumCorners) ? corners[NumCorners - 1 - i] : $random(seed);
            runMulti(op, a, b, 0);
        end
    endtask

    initial begin
        #(WatchdogNs);
        $display("watchdog expired after %0d ns, a test never finished", WatchdogNs);
        $display("ERRORS FOUND");
        $finish;
    end

    initial begin
        int          mark;
        logic [31:0] a;
        logic [31:0] b;
        clk    = 1'b0;
        rstN   = 1'b0;
        exReq  = '0;
        stall  = 1'b0;
        flush  = 1'b0;
        seed   = 32'h9a3b;
        errors = 0;
        checks = 0;
        applyReq(aluPkg::Nop, 32'h0, 32'h0, 5'd0);
        repeat (ResetCycles) @(posedge clk);
        #DriveDelay;
        rstN = 1'b1;
        @(negedge clk);
        checkValue("aluStall_o", aluStall, 1'b0);
        checkValue("hiloWr_o.write", hiloWr.write, 1'b0);

        mark = errors;
        for (int k = 0; k < NumSingleOps; k++) begin
            for (int i = 0; i < RunsPerOp; i++) begin
                a = (i < NumCorners) ? corners[i] : $random(seed);
                b = (i < NumCorners) ? corners[(i + 2) % NumCorners] : $random(seed);
                runSingle(singleOps[k], a, b, 5'(i * 7 + k));
            end
        end
        endTest("single-cycle operations", mark);

        mark = errors;
        for (int k = 0; k < 4; k++) begin
            for (int i = 0; i < NumCorners; i++) begin
                runSingle(singleOps[k], ovfA[i], ovfB[i], 5'd0);
            end
        end
        endTest("add/sub overflow", mark);

        mark = errors;
        a = $random(seed);
        runMove(aluPkg::Mthi, a, 1'b0);
        runMove(aluPkg::Mtlo, ~a, 1'b0);
        runMove(aluPkg::Mthi, corners[5], 1'b1);
        runMove(aluPkg::Mtlo, corners[2], 1'b1);
        endTest("HI/LO moves", mark);

        mark = errors;
        sweepMulti(aluPkg::Mult);
        sweepMulti(aluPkg::Multu);
        endTest("multiply", mark);

        mark = errors;
        sweepMulti(aluPkg::Div);
        sweepMulti(aluPkg::Divu);
        runMulti(aluPkg::Div, 32'h8000_0000, 32'hffff_ffff, 0);
        runMulti(aluPkg::Divu, $random(seed), 32'h0, 0);
        runMulti(aluPkg::Div, 32'hffff_ff85, 32'h0000_000b, 3); // -123 / 11 under a late stall
        endTest("divide", mark);

        mark = errors;
        nextCycle();
        stall = 1'b0;
        applyReq(aluPkg::Mult, $random(seed), $random(seed), 5'd0);
        repeat (5) nextCycle();
        flush = 1'b1;
        @(negedge clk);
        checkValue("hiloWr_o.write", hiloWr.write, 1'b0);
        nextCycle();
        flush = 1'b0;
        applyReq(aluPkg::Nop, 32'h0, 32'h0, 5'd0);
        runMulti(aluPkg::Mult, 32'hffff_fffd, 32'h0000_0007, 0);
        runSingle(aluPkg::Addu, $random(seed), $random(seed), 5'd0);
        endTest("flush during multiply", mark);

        nextCycle();
        applyReq(aluPkg::Nop, 32'h0, 32'h0, 5'd0);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: executeStage.f
rtl/aluPkg.sv
rtl/hiloPkg.sv
rtl/seqMultiplier.sv
rtl/seqDivider.sv
rtl/aluCore.sv
rtl/executeStage.sv
testbench/executeStage_checker.sv
testbench/executeStage_tb.sv

// File: Makefile
VERILATOR := verilator
TOP       := executeStage_tb
FILELIST  := executeStage.f
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
PASS_MSG  := NO ERRORS

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
